// File: common/mcontr_enc_pkg.sv
/*
 * Shared definitions for the DDR3 command sequence encoders:
 * encoded command word, page request, memory command codes
 * and the functions that pack a command or a pause word.
 */
package mcontr_enc_pkg;

    localparam int CMD_PAUSE_BITS = 10;            // width of a pause count
    localparam int CMD_DONE_BIT   = 10;            // done flag position inside addr of a pause

    typedef enum logic [2:0] {
        NOP       = 3'd0,
        READ      = 3'd2,
        WRITE     = 3'd3,
        ACTIVATE  = 3'd4,
        PRECHARGE = 3'd5
    } rcw_e;                                       // RAS/CAS/WE, positive logic

    typedef enum logic {
        SRC_RD = 1'b0,
        SRC_WR = 1'b1
    } seq_src_e;

    typedef struct packed {
        logic [14:0] addr;                         // row/column, or pause count + done
        logic [2:0]  bank;
        logic [2:0]  rcw;
        logic        odt_en;
        logic        cke;
        logic        sel;                          // first/second half-cycle
        logic        dq_en;                        // drive DQ lines
        logic        dqs_en;                       // drive DQS lines
        logic        dqs_toggle;                   // toggle DQS per pattern
        logic        dci;
        logic        buf_wr;                       // write to external buffer
        logic        buf_rd;                       // read from external buffer
        logic        nop;                          // add NOP after this command
        logic        buf_rst;                      // advance external buffer page
    } enc_cmd_t;

    typedef struct packed {
        logic [2:0]  bank;
        logic [14:0] row;
        logic [6:0]  start_col;                    // in 8-bursts
        logic [5:0]  num128;                       // 0 means 64
        logic        skip_next_page;               // keep external buffer page
    } page_req_t;

    function automatic enc_cmd_t encode_cmd(
        input logic [14:0] addr,
        input logic [2:0]  bank,
        input rcw_e        rcw,
        input logic        odt_en,
        input logic        cke,
        input logic        sel,
        input logic        dq_en,
        input logic        dqs_en,
        input logic        dqs_toggle,
        input logic        dci,
        input logic        buf_wr,
        input logic        buf_rd,
        input logic        nop,
        input logic        buf_rst
    );
        return '{addr, bank, rcw, odt_en, cke, sel, dq_en, dqs_en, dqs_toggle,
                 dci, buf_wr, buf_rd, nop, buf_rst};
    endfunction

    // pause keeps all control bits for skip+1 cycles
    function automatic enc_cmd_t encode_skip(
        input logic [CMD_PAUSE_BITS-1:0] skip,
        input logic                      done,
        input logic [2:0]                bank,
        input logic                      odt_en,
        input logic                      cke,
        input logic                      sel,
        input logic                      dq_en,
        input logic                      dqs_en,
        input logic                      dqs_toggle,
        input logic                      dci,
        input logic                      buf_wr,
        input logic                      buf_rd,
        input logic                      buf_rst
    );
        logic [14:0] addr;
        addr                       = '0;
        addr[CMD_PAUSE_BITS-1:0]   = skip;
        addr[CMD_DONE_BIT]         = done;         // end of sequence
        return encode_cmd(addr, bank, NOP, odt_en, cke, sel, dq_en, dqs_en, dqs_toggle,
                          dci, buf_wr, buf_rd, 1'b0, buf_rst);
    endfunction

endpackage

// File: cmd_encod/cmd_encod_linear_rd.sv
`timescale 1ns/10ps
/*
 * Linear page read encoder. Opens one row, issues a run of READ
 * 8-bursts from a start column, then closes the row. Sequence
 * comes from a small registered ROM with a repeat loop on READ.
 */
module cmd_encod_linear_rd #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10,
    parameter int NUM_XFER_BITS  = 6
) (
    input  logic                      rst,       // clock
    input  logic                      clk,       // async reset, active high
    input  mcontr_enc_pkg::page_req_t req,
    input  logic                      start,
    output mcontr_enc_pkg::enc_cmd_t  enc_cmd,
    output logic                      enc_wr,
    output logic                      enc_done
);
    import mcontr_enc_pkg::*;

    localparam logic [1:0] C_NOP  = 2'd0;          // local 2-bit command codes
    localparam logic [1:0] C_XFER = 2'd1;
    localparam logic [1:0] C_PRE  = 2'd2;
    localparam logic [1:0] C_ACT  = 2'd3;
    localparam logic [3:0] REPEAT_ADDR = 4'd3;     // READ loop entry

    typedef struct packed {
        logic       last;                          // final word, carries done
        logic       pgnext;                        // buf_rst request
        logic [1:0] pause;
        logic [1:0] cmd;
        logic       sel;
        logic       dci;
        logic       buf_wr;
        logic       nop;
    } rom_t;

    logic [ADDRESS_NUMBER-1:0] row;
    logic [COLADDR_NUMBER-4:0] col;                // column in 8-bursts
    logic [2:0]                bank;
    logic                      skip_next_page;
    logic [NUM_XFER_BITS-1:0]  num128;             // bursts remaining
    logic                      gen_run;
    logic [3:0]                gen_addr;
    rom_t                      rom_r;
    logic                      one_left;
    logic [ADDRESS_NUMBER-1:0] cmd_addr;
    rcw_e                      rcw;

    assign one_left = (num128 == NUM_XFER_BITS'(1));
    assign cmd_addr = rom_r.cmd[1] ? row :         // ACT/PRE take the row
                      {{(ADDRESS_NUMBER-COLADDR_NUMBER){1'b0}}, col, 3'b000};

    always_comb begin
        case (rom_r.cmd)
            C_ACT:   rcw = ACTIVATE;
            C_PRE:   rcw = PRECHARGE;
            C_XFER:  rcw = READ;
            default: rcw = NOP;
        endcase
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            gen_run  <= 1'b0;
            gen_addr <= '0;
            num128   <= '0;
        end else begin
            if (start)
                gen_run <= 1'b1;
            else if (rom_r.last)
                gen_run <= 1'b0;                   // last word reached the ROM output
            if (!start && !gen_run)
                gen_addr <= '0;
            else if (gen_addr == REPEAT_ADDR - 4'd1 && one_left)
                gen_addr <= REPEAT_ADDR + 4'd1;    // single burst, skip the loop
            else if (gen_addr != REPEAT_ADDR || one_left)
                gen_addr <= gen_addr + 4'd1;
            if (start)
                num128 <= req.num128;
            else if (gen_addr == REPEAT_ADDR - 4'd1 || gen_addr == REPEAT_ADDR)
                num128 <= num128 - 1'b1;           // one per READ entry
        end
    end

    always_ff @(posedge rst) begin
        if (start) begin
            row            <= req.row;
            bank           <= req.bank;
            skip_next_page <= req.skip_next_page;
        end
        if (start)
            col <= req.start_col;
        else if (rom_r.cmd == C_XFER)
            col <= col + 1'b1;                     // next burst column
    end

    // fields: last pgnext pause cmd sel dci buf_wr nop
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rom_r <= '0;
        end else begin
            case (gen_addr)
                4'h0: rom_r <= '{1'b0, 1'b0, 2'd0, C_ACT,  1'b0, 1'b0, 1'b0, 1'b0};
                4'h1: rom_r <= '{1'b0, 1'b0, 2'd1, C_NOP,  1'b0, 1'b0, 1'b0, 1'b0};
                4'h2: rom_r <= '{1'b0, 1'b0, 2'd0, C_XFER, 1'b1, 1'b1, 1'b0, 1'b1};
                4'h3: rom_r <= '{1'b0, 1'b0, 2'd0, C_XFER, 1'b1, 1'b1, 1'b1, 1'b1};
                4'h4: rom_r <= '{1'b0, 1'b0, 2'd1, C_NOP,  1'b1, 1'b1, 1'b1, 1'b0};
                4'h5: rom_r <= '{1'b0, 1'b1, 2'd0, C_NOP,  1'b1, 1'b1, 1'b0, 1'b0};
                4'h6: rom_r <= '{1'b0, 1'b0, 2'd0, C_PRE,  1'b0, 1'b1, 1'b0, 1'b0};
                4'h7: rom_r <= '{1'b0, 1'b0, 2'd2, C_NOP,  1'b0, 1'b1, 1'b0, 1'b0};
                4'h8: rom_r <= '{1'b1, 1'b0, 2'd0, C_NOP,  1'b0, 1'b0, 1'b0, 1'b0};
                default: rom_r <= '0;
            endcase
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end else begin
            enc_wr   <= gen_run;
            enc_done <= enc_wr && !gen_run;        // one cycle after the last word
        end
    end

    always_ff @(posedge rst) begin
        if (rom_r.cmd == C_NOP)
            enc_cmd <= encode_skip(CMD_PAUSE_BITS'(rom_r.pause), rom_r.last, bank,
                                   1'b0, 1'b0, rom_r.sel, 1'b0, 1'b0, 1'b0, rom_r.dci,
                                   rom_r.buf_wr, 1'b0, rom_r.pgnext && !skip_next_page);
        else
            enc_cmd <= encode_cmd(cmd_addr, bank, rcw,
                                  1'b0, 1'b0, rom_r.sel, 1'b0, 1'b0, 1'b0, rom_r.dci,
                                  rom_r.buf_wr, 1'b0, rom_r.nop,
                                  rom_r.pgnext && !skip_next_page);
    end

endmodule

// File: cmd_encod/cmd_encod_linear_wr.sv
`timescale 1ns/10ps
/*
 * Linear page write encoder. Same ROM skeleton as the read side,
 * with WRITE bursts fed from the external buffer one command ahead
 * and DQ, DQS and ODT driven across the WRITE run.
 */
module cmd_encod_linear_wr #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10,
    parameter int NUM_XFER_BITS  = 6
) (
    input  logic                      rst,       // clock
    input  logic                      clk,       // async reset, active high
    input  mcontr_enc_pkg::page_req_t req,
    input  logic                      start,
    output mcontr_enc_pkg::enc_cmd_t  enc_cmd,
    output logic                      enc_wr,
    output logic                      enc_done
);
    import mcontr_enc_pkg::*;

    localparam logic [1:0] C_NOP  = 2'd0;
    localparam logic [1:0] C_XFER = 2'd1;
    localparam logic [1:0] C_PRE  = 2'd2;
    localparam logic [1:0] C_ACT  = 2'd3;
    localparam logic [3:0] REPEAT_ADDR = 4'd3;     // WRITE loop entry

    typedef struct packed {
        logic       last;
        logic       pgnext;
        logic [1:0] pause;
        logic [1:0] cmd;
        logic       sel;
        logic       buf_rd;                        // fetch data for the next WRITE
        logic       wdata;                         // DQ/DQS/ODT enables
        logic       nop;
    } rom_t;

    logic [ADDRESS_NUMBER-1:0] row;
    logic [COLADDR_NUMBER-4:0] col;
    logic [2:0]                bank;
    logic                      skip_next_page;
    logic [NUM_XFER_BITS-1:0]  num128;
    logic                      gen_run;
    logic [3:0]                gen_addr;
    rom_t                      rom_r;
    logic                      burst_last;         // rom_r holds the final WRITE
    logic                      one_left;
    logic                      buf_rd_lead;
    logic [ADDRESS_NUMBER-1:0] cmd_addr;
    rcw_e                      rcw;

    assign one_left    = (num128 == NUM_XFER_BITS'(1));
    assign buf_rd_lead = rom_r.buf_rd && !(rom_r.cmd == C_XFER && burst_last);
    assign cmd_addr    = rom_r.cmd[1] ? row :
                         {{(ADDRESS_NUMBER-COLADDR_NUMBER){1'b0}}, col, 3'b000};

    always_comb begin
        case (rom_r.cmd)
            C_ACT:   rcw = ACTIVATE;
            C_PRE:   rcw = PRECHARGE;
            C_XFER:  rcw = WRITE;
            default: rcw = NOP;
        endcase
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            gen_run  <= 1'b0;
            gen_addr <= '0;
            num128   <= '0;
        end else begin
            if (start)
                gen_run <= 1'b1;
            else if (rom_r.last)
                gen_run <= 1'b0;
            if (!start && !gen_run)
                gen_addr <= '0;
            else if (gen_addr == REPEAT_ADDR - 4'd1 && one_left)
                gen_addr <= REPEAT_ADDR + 4'd1;    // no loop for one burst
            else if (gen_addr != REPEAT_ADDR || one_left)
                gen_addr <= gen_addr + 4'd1;
            if (start)
                num128 <= req.num128;
            else if (gen_addr == REPEAT_ADDR - 4'd1 || gen_addr == REPEAT_ADDR)
                num128 <= num128 - 1'b1;
        end
    end

    always_ff @(posedge rst) begin
        if (start) begin
            row            <= req.row;
            bank           <= req.bank;
            skip_next_page <= req.skip_next_page;
        end
        if (start)
            col <= req.start_col;
        else if (rom_r.cmd == C_XFER)
            col <= col + 1'b1;                     // one column step per WRITE
    end

    // fields: last pgnext pause cmd sel buf_rd wdata nop
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rom_r      <= '0;
            burst_last <= 1'b0;
        end else begin
            burst_last <= one_left;                // valid while rom_r is a WRITE
            case (gen_addr)
                4'h0: rom_r <= '{1'b0, 1'b0, 2'd0, C_ACT,  1'b0, 1'b0, 1'b0, 1'b0};
                4'h1: rom_r <= '{1'b0, 1'b0, 2'd1, C_NOP,  1'b0, 1'b1, 1'b0, 1'b0};
                4'h2: rom_r <= '{1'b0, 1'b0, 2'd0, C_XFER, 1'b1, 1'b1, 1'b1, 1'b1};
                4'h3: rom_r <= '{1'b0, 1'b0, 2'd0, C_XFER, 1'b1, 1'b1, 1'b1, 1'b1};
                4'h4: rom_r <= '{1'b0, 1'b0, 2'd1, C_NOP,  1'b1, 1'b0, 1'b0, 1'b0};
                4'h5: rom_r <= '{1'b0, 1'b1, 2'd0, C_NOP,  1'b1, 1'b0, 1'b0, 1'b0};
                4'h6: rom_r <= '{1'b0, 1'b0, 2'd0, C_PRE,  1'b0, 1'b0, 1'b0, 1'b0};
                4'h7: rom_r <= '{1'b0, 1'b0, 2'd2, C_NOP,  1'b0, 1'b0, 1'b0, 1'b0};
                4'h8: rom_r <= '{1'b1, 1'b0, 2'd0, C_NOP,  1'b0, 1'b0, 1'b0, 1'b0};
                default: rom_r <= '0;
            endcase
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end else begin
            enc_wr   <= gen_run;
            enc_done <= enc_wr && !gen_run;
        end
    end

    always_ff @(posedge rst) begin
        if (rom_r.cmd == C_NOP)
            enc_cmd <= encode_skip(CMD_PAUSE_BITS'(rom_r.pause), rom_r.last, bank,
                                   rom_r.wdata, 1'b0, rom_r.sel, rom_r.wdata, rom_r.wdata,
                                   rom_r.wdata, 1'b0, 1'b0, buf_rd_lead,
                                   rom_r.pgnext && !skip_next_page);
        else
            enc_cmd <= encode_cmd(cmd_addr, bank, rcw,
                                  rom_r.wdata, 1'b0, rom_r.sel, rom_r.wdata, rom_r.wdata,
                                  rom_r.wdata, 1'b0, 1'b0, buf_rd_lead, rom_r.nop,
                                  rom_r.pgnext && !skip_next_page);
    end

endmodule

// File: cmd_encod/cmd_seq_writer.sv
`timescale 1ns/10ps
/*
 * Command sequence memory. Stores the words of whichever encoder
 * strobes at consecutive addresses, latches length and source at
 * the end of each sequence and gives registered readback.
 */
module cmd_seq_writer #(
    parameter int SEQ_ADDR_BITS = 6
) (
    input  logic                     rst,        // clock
    input  logic                     clk,        // async reset, active high
    input  mcontr_enc_pkg::enc_cmd_t rd_cmd,
    input  logic                     rd_wr,
    input  logic                     rd_done,
    input  mcontr_enc_pkg::enc_cmd_t wr_cmd,
    input  logic                     wr_wr,
    input  logic                     wr_done,
    input  logic [SEQ_ADDR_BITS-1:0] rd_addr,
    output mcontr_enc_pkg::enc_cmd_t rd_data,
    output logic [SEQ_ADDR_BITS:0]   seq_len,
    output mcontr_enc_pkg::seq_src_e seq_src,
    output logic                     seq_done
);
    import mcontr_enc_pkg::*;

    localparam int SEQ_DEPTH = 2 ** SEQ_ADDR_BITS;

    enc_cmd_t               mem [SEQ_DEPTH];
    enc_cmd_t               wr_word;
    logic                   wr_en;
    logic                   seq_end;
    logic [SEQ_ADDR_BITS:0] wr_cnt;                // running address, also word count

    assign wr_en   = rd_wr || wr_wr;               // encoders never overlap
    assign wr_word = rd_wr ? rd_cmd : wr_cmd;
    assign seq_end = rd_done || wr_done;

    always_ff @(posedge rst) begin
        if (wr_en)
            mem[wr_cnt[SEQ_ADDR_BITS-1:0]] <= wr_word;
        rd_data <= mem[rd_addr];                   // one cycle read latency
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wr_cnt   <= '0;
            seq_len  <= '0;
            seq_src  <= SRC_RD;
            seq_done <= 1'b0;
        end else begin
            seq_done <= seq_end;
            if (seq_end) begin
                wr_cnt  <= '0;                     // next sequence starts at 0
                seq_len <= wr_cnt;
                seq_src <= rd_done ? SRC_RD : SRC_WR;
            end else if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

endmodule

// File: source/cmd_encod_linear_top.sv
`timescale 1ns/10ps
/*
 * Linear page command encoder subsystem. Read and write encoders
 * feed one shared command sequence memory.
 */
module cmd_encod_linear_top #(
    parameter int ADDRESS_NUMBER = 15,
    parameter int COLADDR_NUMBER = 10,
    parameter int NUM_XFER_BITS  = 6,
    parameter int SEQ_ADDR_BITS  = 7             // holds a full 64-burst sequence
) (
    input  logic                      rst,       // clock
    input  logic                      clk,       // async reset, active high
    input  mcontr_enc_pkg::page_req_t req,
    input  logic                      start_rd,
    input  logic                      start_wr,
    input  logic [SEQ_ADDR_BITS-1:0]  rd_addr,
    output mcontr_enc_pkg::enc_cmd_t  rd_data,
    output logic [SEQ_ADDR_BITS:0]    seq_len,
    output mcontr_enc_pkg::seq_src_e  seq_src,
    output logic                      seq_done
);
    import mcontr_enc_pkg::*;

    enc_cmd_t rd_cmd;
    logic     rd_wr;
    logic     rd_done;
    enc_cmd_t wr_cmd;
    logic     wr_wr;
    logic     wr_done;

    cmd_encod_linear_rd #(
        .ADDRESS_NUMBER (ADDRESS_NUMBER),
        .COLADDR_NUMBER (COLADDR_NUMBER),
        .NUM_XFER_BITS  (NUM_XFER_BITS)
    ) u_rd (
        .rst      (rst),
        .clk      (clk),
        .req      (req),
        .start    (start_rd),
        .enc_cmd  (rd_cmd),
        .enc_wr   (rd_wr),
        .enc_done (rd_done)
    );

    cmd_encod_linear_wr #(
        .ADDRESS_NUMBER (ADDRESS_NUMBER),
        .COLADDR_NUMBER (COLADDR_NUMBER),
        .NUM_XFER_BITS  (NUM_XFER_BITS)
    ) u_wr (
        .rst      (rst),
        .clk      (clk),
        .req      (req),
        .start    (start_wr),
        .enc_cmd  (wr_cmd),
        .enc_wr   (wr_wr),
        .enc_done (wr_done)
    );

    cmd_seq_writer #(
        .SEQ_ADDR_BITS (SEQ_ADDR_BITS)
    ) u_seq (
        .rst      (rst),
        .clk      (clk),
        .rd_cmd   (rd_cmd),
        .rd_wr    (rd_wr),
        .rd_done  (rd_done),
        .wr_cmd   (wr_cmd),
        .wr_wr    (wr_wr),
        .wr_done  (wr_done),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .seq_len  (seq_len),
        .seq_src  (seq_src),
        .seq_done (seq_done)
    );

endmodule

// File: dv/cmd_encod_linear_checker.sv
`timescale 1ns/10ps
/*
 * Concurrent assertions on the command sequence structure,
 * bound into the encoder subsystem top level.
 */
module cmd_encod_linear_checker (
    input logic                     rst,           // clock
    input logic                     clk,           // async reset, active high
    input logic                     start_rd,
    input logic                     start_wr,
    input mcontr_enc_pkg::enc_cmd_t rd_cmd,
    input logic                     rd_wr,
    input logic                     rd_done,
    input mcontr_enc_pkg::enc_cmd_t wr_cmd,
    input logic                     wr_wr,
    input logic                     wr_done,
    input logic                     seq_done
);
    import mcontr_enc_pkg::*;

    int       assert_fails = 0;                    // read by the testbench
    logic     strobe;
    logic     seq_end;
    logic     idle;                                // between enc_done and next start
    logic     first_due;                           // next stored word opens a sequence
    enc_cmd_t cmd;

    assign strobe  = rd_wr || wr_wr;
    assign seq_end = rd_done || wr_done;
    assign cmd     = rd_wr ? rd_cmd : wr_cmd;      // same select as the writer

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            idle      <= 1'b1;
            first_due <= 1'b1;
        end else begin
            if (start_rd || start_wr)
                idle <= 1'b0;
            else if (seq_end)
                idle <= 1'b1;
            if (seq_end)
                first_due <= 1'b1;
            else if (strobe)
                first_due <= 1'b0;
        end
    end

    a_no_burst_idle: assert property (@(posedge rst) disable iff (clk)
        (idle && strobe) |-> (cmd.rcw != READ && cmd.rcw != WRITE))
        else begin
            assert_fails++;
            $error("burst command stored between enc_done and the next start");
        end

    a_first_act: assert property (@(posedge rst) disable iff (clk)
        (strobe && first_due) |-> (cmd.rcw == ACTIVATE))
        else begin
            assert_fails++;
            $error("first stored command of a sequence is not ACTIVATE");
        end

    a_done_follow: assert property (@(posedge rst) disable iff (clk)
        seq_end |=> seq_done)
        else begin
            assert_fails++;
            $error("seq_done missing one clock after enc_done");
        end

    a_one_source: assert property (@(posedge rst) disable iff (clk)
        !(rd_wr && wr_wr))
        else begin
            assert_fails++;
            $error("both encoders strobe in the same cycle");
        end

endmodule

bind cmd_encod_linear_top cmd_encod_linear_checker u_checker (
    .rst      (rst),
    .clk      (clk),
    .start_rd (start_rd),
    .start_wr (start_wr),
    .rd_cmd   (rd_cmd),
    .rd_wr    (rd_wr),
    .rd_done  (rd_done),
    .wr_cmd   (wr_cmd),
    .wr_wr    (wr_wr),
    .wr_done  (wr_done),
    .seq_done (seq_done)
);

// File: dv/cmd_encod_linear_tb.sv
`timescale 1ns/10ps
/*
 * Testbench for the linear page command encoder subsystem.
 * Random read and write page requests, full readback of each
 * stored sequence, word by word check against the page rules.
 */
module cmd_encod_linear_tb;
    import mcontr_enc_pkg::*;

    localparam int SEQ_ADDR_BITS = 7;              // room for a 64-burst page
    localparam int WAIT_LIMIT    = 300;            // cycles allowed for one sequence

    logic                     rst;                 // clock
    logic                     clk;                 // reset
    page_req_t                req;
    logic                     start_rd;
    logic                     start_wr;
    logic [SEQ_ADDR_BITS-1:0] rd_addr;
    enc_cmd_t                 rd_data;
    logic [SEQ_ADDR_BITS:0]   seq_len;
    seq_src_e                 seq_src;
    logic                     seq_done;

    int       seed           = 57722;
    int       mismatch_count = 0;
    int       timeout_count  = 0;
    enc_cmd_t words [2**SEQ_ADDR_BITS];            // readback of the last sequence

    cmd_encod_linear_top #(
        .ADDRESS_NUMBER (15),
        .COLADDR_NUMBER (10),
        .NUM_XFER_BITS  (6),
        .SEQ_ADDR_BITS  (SEQ_ADDR_BITS)
    ) u_dut (
        .rst      (rst),
        .clk      (clk),
        .req      (req),
        .start_rd (start_rd),
        .start_wr (start_wr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .seq_len  (seq_len),
        .seq_src  (seq_src),
        .seq_done (seq_done)
    );

    initial begin
        rst = 1'b0;
        forever #2 rst = ~rst;                     // 4 ns period
    end

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else begin
            mismatch_count++;
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic page_req_t random_req();
        page_req_t r;
        r.bank           = 3'($random(seed));
        r.row            = 15'($random(seed));
        r.start_col      = 7'($random(seed));
        r.num128         = 6'($random(seed));
        r.skip_next_page = 1'($random(seed));
        return r;
    endfunction

    task automatic read_word(input int idx, output enc_cmd_t w);
        @(posedge rst);
        rd_addr <= SEQ_ADDR_BITS'(idx);
        @(posedge rst);                            // memory registers the word here
        @(negedge rst);
        w = rd_data;
    endtask

    // expected words are ACT, pause 1, N bursts, 2 NOPs, PRE, pause 2 and done
    task automatic check_words(input bit is_write, input page_req_t r, input int n);
        int         i;
        int         rst_cnt;
        logic       xfer;
        logic       next_xfer;
        logic [2:0] exp_rcw;
        logic [6:0] col;
        string      tag;
        rst_cnt = 0;
        for (i = 0; i < n + 7; i++) begin
            tag       = $sformatf("word %0d", i);
            xfer      = (i >= 2 && i < n + 2);
            next_xfer = (i >= 1 && i < n + 1);     // the following word is a burst
            col       = r.start_col + 7'(i - 2);
            if (i == 0)
                exp_rcw = ACTIVATE;
            else if (xfer)
                exp_rcw = is_write ? WRITE : READ;
            else if (i == n + 4)
                exp_rcw = PRECHARGE;
            else
                exp_rcw = NOP;
            expect_equal({tag, " rcw"}, words[i].rcw, exp_rcw);
            expect_equal({tag, " bank"}, words[i].bank, r.bank);
            if (i == 0)
                expect_equal({tag, " addr"}, words[i].addr, r.row);
            if (i == 1)
                expect_equal({tag, " addr"}, words[i].addr, 1);
            if (xfer)
                expect_equal({tag, " addr"}, words[i].addr, {5'b0, col, 3'b000});
            if (i == n + 5)
                expect_equal({tag, " addr"}, words[i].addr, 2);
            if (exp_rcw == NOP)
                expect_equal({tag, " done"}, words[i].addr[CMD_DONE_BIT], i == n + 6);
            if (is_write) begin
                expect_equal({tag, " buf_rd"}, words[i].buf_rd, next_xfer);
                expect_equal({tag, " dq_en"}, words[i].dq_en, xfer);
                expect_equal({tag, " dqs_en"}, words[i].dqs_en, xfer);
                expect_equal({tag, " odt_en"}, words[i].odt_en, xfer);
            end else begin
                expect_equal({tag, " buf_rd"}, words[i].buf_rd, 1'b0);
                expect_equal({tag, " dq_en"}, words[i].dq_en, 1'b0);
                expect_equal({tag, " dqs_en"}, words[i].dqs_en, 1'b0);
                expect_equal({tag, " odt_en"}, words[i].odt_en, 1'b0);
            end
            rst_cnt += words[i].buf_rst;
        end
        if (!is_write)
            expect_equal($sformatf("word %0d buf_wr", n + 2), words[n + 2].buf_wr, 1'b1);
        expect_equal("buf_rst count", rst_cnt, r.skip_next_page ? 0 : 1);
    endtask

    task automatic run_page(input bit is_write, input page_req_t r);
        int i;
        int n;
        int cycles;
        @(posedge rst);
        req      <= r;
        start_rd <= !is_write;
        start_wr <= is_write;
        @(posedge rst);
        start_rd <= 1'b0;                          // single-cycle start
        start_wr <= 1'b0;
        cycles = 0;
        @(negedge rst);
        while (!seq_done && cycles < WAIT_LIMIT) begin
            @(negedge rst);
            cycles++;
        end
        if (!seq_done) begin
            timeout_count++;
            $display("timeout: no seq_done within %0d cycles after a %s request",
                     WAIT_LIMIT, is_write ? "write" : "read");
        end else begin
            n = (r.num128 == 0) ? 64 : int'(r.num128);
            expect_equal("seq_len", seq_len, n + 7);
            expect_equal("seq_src", seq_src, is_write ? SRC_WR : SRC_RD);
            for (i = 0; i < n + 7; i++)
                read_word(i, words[i]);
            check_words(is_write, r, n);
        end
    endtask

    initial begin
        page_req_t r;
        int        k;
        clk      = 1'b1;                           // reset held from time 0
        req      = '0;
        start_rd = 1'b0;
        start_wr = 1'b0;
        rd_addr  = '0;
        repeat (5) @(posedge rst);
        clk <= 1'b0;
        @(negedge rst);
        expect_equal("seq_done after reset", seq_done, 1'b0);
        expect_equal("seq_len after reset", seq_len, 0);

        r = random_req();
        r.skip_next_page = 1'b0;
        run_page(1'b0, r);                         // random read page
        r = random_req();
        r.num128 = 6'd1;
        r.skip_next_page = 1'b1;
        run_page(1'b0, r);                         // single burst, loop skipped
        r = random_req();
        r.num128 = 6'd0;
        run_page(1'b0, r);                         // full 64 bursts
        r = random_req();
        r.skip_next_page = 1'b1;
        run_page(1'b1, r);
        r = random_req();
        r.num128 = 6'd1;
        run_page(1'b1, r);
        r = random_req();
        r.num128 = 6'd0;
        r.skip_next_page = 1'b0;
        run_page(1'b1, r);
        for (k = 0; k < 20; k++) begin
            r = random_req();
            run_page(k % 2 == 1, r);               // alternate read and write
        end

        $display("checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, u_dut.u_checker.assert_fails);
        if (mismatch_count == 0 && timeout_count == 0 && u_dut.u_checker.assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: cmd_encod_linear_top.f
common/mcontr_enc_pkg.sv
cmd_encod/cmd_encod_linear_rd.sv
cmd_encod/cmd_encod_linear_wr.sv
cmd_encod/cmd_seq_writer.sv
source/cmd_encod_linear_top.sv
dv/cmd_encod_linear_checker.sv
dv/cmd_encod_linear_tb.sv

// File: Bender.yml
package:
  name: cmd_encod_linear

sources:
  - common/mcontr_enc_pkg.sv
  - cmd_encod/cmd_encod_linear_rd.sv
  - cmd_encod/cmd_encod_linear_wr.sv
  - cmd_encod/cmd_seq_writer.sv
  - source/cmd_encod_linear_top.sv
  - target: simulation
    files:
      - dv/cmd_encod_linear_checker.sv
      - dv/cmd_encod_linear_tb.sv
